// ==== design/rsa_cfg.svh ====
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// operand width of the engine; N, y, d and every internal operand use it.
`define RSA_WIDTH 256

// bit counters step through 0 .. RSA_WIDTH-1, so 8 bits cover 256 positions.
`define RSA_CNT_W 8

// the accumulator holds m + b + N before the halving step.
// two guard bits keep that sum from overflowing.
`define RSA_ACC_W (`RSA_WIDTH + 2)

`endif

// ==== design/rsa_pkg.sv ====
`default_nettype none

package rsa_pkg;

    // loop states shared by the Montgomery multiplier and the pre-processor.
    typedef enum logic [1:0] {
        MONT_IDLE = 2'd0,   // waiting for a start strobe.
        MONT_PROC = 2'd1,   // one operand bit per cycle.
        MONT_DONE = 2'd2    // single cycle that raises the done pulse.
    } mont_state_e;

    // sequencer states of the square-and-multiply controller.
    typedef enum logic [2:0] {
        EXP_IDLE   = 3'd0,  // waiting for a user start.
        EXP_PREP   = 3'd1,  // converting y into the Montgomery domain.
        EXP_LAUNCH = 3'd2,  // strobing both multipliers.
        EXP_WAIT   = 3'd3,  // waiting for the multipliers to finish.
        EXP_DONE   = 3'd4   // publishing the result.
    } exp_state_e;

endpackage

`default_nettype wire

// ==== design/rsa_mont.sv ====
`default_nettype none

`include "rsa_cfg.svh"

module rsa_mont
    import rsa_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_start,
    input  wire logic [`RSA_WIDTH-1:0] i_n,
    input  wire logic [`RSA_WIDTH-1:0] i_a,
    input  wire logic [`RSA_WIDTH-1:0] i_b,
    output logic      [`RSA_WIDTH-1:0] o_m,
    output logic                       o_done
);

    localparam int unsigned CNT_W = `RSA_CNT_W;
    localparam int unsigned ACC_W = `RSA_ACC_W;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`RSA_WIDTH - 1);

    mont_state_e state_r;                 // loop state.
    logic [CNT_W-1:0] cnt_r;              // index of the bit of a being consumed.
    logic [ACC_W-1:0] acc_r;              // running Montgomery accumulator.
    logic done_r;                         // registered done pulse.
    logic [`RSA_WIDTH-1:0] n_r;           // modulus captured at start.
    logic [`RSA_WIDTH-1:0] a_r;           // multiplier operand, scanned bit by bit.
    logic [`RSA_WIDTH-1:0] b_r;           // multiplicand operand.
    logic accept;
    logic last_bit;
    logic [ACC_W-1:0] sum_ab;
    logic [ACC_W-1:0] sum_abn;
    logic [ACC_W-1:0] acc_half;
    logic [ACC_W-1:0] acc_next;

    assign accept = (state_r == MONT_IDLE) && i_start; // a start is taken only while idle.
    assign last_bit = (cnt_r == LAST_IDX);

    // add b when the current bit of a is set.
    assign sum_ab = acc_r + (a_r[cnt_r] ? ACC_W'(b_r) : '0);
    // an odd sum gets N added so that the halving below is exact modulo N.
    assign sum_abn = sum_ab + (sum_ab[0] ? ACC_W'(n_r) : '0);
    assign acc_half = sum_abn >> 1;

    // the accumulator stays below 2N, so one subtraction after the last bit reduces it.
    assign acc_next = (last_bit && (acc_half >= ACC_W'(n_r))) ? acc_half - ACC_W'(n_r)
                                                               : acc_half;

    assign o_m = acc_r[`RSA_WIDTH-1:0]; // upper guard bits are zero once reduced.
    assign o_done = done_r;

    // operands are sampled once, so the caller may change its inputs during the run.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            n_r <= i_n;
            a_r <= i_a;
            b_r <= i_b;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r <= MONT_IDLE;
            cnt_r   <= '0;
            acc_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0; // the done strobe lasts a single cycle.
            case (state_r)
                MONT_IDLE: begin
                    if (accept) begin
                        cnt_r   <= '0;
                        acc_r   <= '0;
                        state_r <= MONT_PROC;
                    end
                end
                MONT_PROC: begin
                    acc_r <= acc_next;
                    cnt_r <= cnt_r + 1'b1;
                    if (last_bit) begin
                        state_r <= MONT_DONE; // 256 bits consumed.
                    end
                end
                MONT_DONE: begin
                    done_r  <= 1'b1;
                    state_r <= MONT_IDLE;
                end
                default: state_r <= MONT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rsa_prep.sv ====
`default_nettype none

`include "rsa_cfg.svh"

module rsa_prep
    import rsa_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_start,
    input  wire logic [`RSA_WIDTH-1:0] i_n,
    input  wire logic [`RSA_WIDTH-1:0] i_y,
    output logic      [`RSA_WIDTH-1:0] o_t,
    output logic                       o_done
);

    localparam int unsigned CNT_W = `RSA_CNT_W;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`RSA_WIDTH - 1);

    mont_state_e state_r;
    logic [CNT_W-1:0] cnt_r;              // number of doublings done so far.
    logic [`RSA_WIDTH-1:0] t_r;           // running value, always below N.
    logic [`RSA_WIDTH-1:0] n_r;           // modulus captured at start.
    logic done_r;
    logic accept;
    logic [`RSA_WIDTH:0] dbl;             // doubled value needs one extra bit.
    logic [`RSA_WIDTH:0] n_ext;
    logic [`RSA_WIDTH:0] red;

    assign accept = (state_r == MONT_IDLE) && i_start;

    // t < N means 2t < 2N, so a single subtraction keeps the value reduced.
    assign dbl = {t_r, 1'b0};
    assign n_ext = {1'b0, n_r};
    assign red = (dbl >= n_ext) ? dbl - n_ext : dbl;

    assign o_t = t_r;       // held until the next start.
    assign o_done = done_r;

    always_ff @(posedge i_clk) begin
        if (accept) begin
            n_r <= i_n;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r <= MONT_IDLE;
            cnt_r   <= '0;
            t_r     <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                MONT_IDLE: if (accept) begin
                    t_r     <= i_y; // y is assumed already below N.
                    cnt_r   <= '0;
                    state_r <= MONT_PROC;
                end
                MONT_PROC: begin
                    t_r   <= red[`RSA_WIDTH-1:0];
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == LAST_IDX) state_r <= MONT_DONE; // 256 doublings give y*R mod N.
                end
                MONT_DONE: begin
                    done_r  <= 1'b1;
                    state_r <= MONT_IDLE;
                end
                default: state_r <= MONT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rsa_exp_ctrl.sv ====
`default_nettype none

`include "rsa_cfg.svh"

module rsa_exp_ctrl
    import rsa_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_start,
    input  wire logic                  i_prep_done,
    input  wire logic                  i_mont_done,
    input  wire logic [`RSA_WIDTH-1:0] i_n,
    input  wire logic [`RSA_WIDTH-1:0] i_y,
    input  wire logic [`RSA_WIDTH-1:0] i_d,
    input  wire logic [`RSA_WIDTH-1:0] i_prep_t,
    input  wire logic [`RSA_WIDTH-1:0] i_mul_m,
    input  wire logic [`RSA_WIDTH-1:0] i_sq_m,
    output logic                       o_prep_start,
    output logic                       o_mont_start,
    output logic      [`RSA_WIDTH-1:0] o_n,
    output logic      [`RSA_WIDTH-1:0] o_y,
    output logic      [`RSA_WIDTH-1:0] o_m,
    output logic      [`RSA_WIDTH-1:0] o_t,
    output logic      [`RSA_WIDTH-1:0] o_result,
    output logic                       o_busy,
    output logic                       o_done
);

    localparam int unsigned W = `RSA_WIDTH;
    localparam int unsigned CNT_W = `RSA_CNT_W;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`RSA_WIDTH - 1);

    exp_state_e state_r;
    logic [CNT_W-1:0] bit_r;    // exponent bit handled by the current round.
    logic [W-1:0] n_r;          // modulus for the whole run.
    logic [W-1:0] y_r;          // base, fed to the pre-processor.
    logic [W-1:0] d_r;          // exponent, scanned from bit 0 upward.
    logic [W-1:0] m_r;          // running result, kept out of the Montgomery domain.
    logic [W-1:0] t_r;          // running power y^(2^i) times R mod N.
    logic prep_start_r;
    logic accept;
    logic exp_bit;
    logic last_round;

    assign accept = (state_r == EXP_IDLE) && i_start; // starts during a run are dropped.
    assign exp_bit = d_r[bit_r];
    assign last_round = (bit_r == LAST_IDX);

    assign o_prep_start = prep_start_r;
    // both multipliers share this strobe and so finish on the same cycle.
    assign o_mont_start = (state_r == EXP_LAUNCH);
    assign o_n = n_r;
    assign o_y = y_r;
    assign o_m = m_r;
    assign o_t = t_r;

    // user operands only need to be stable in the cycle of the accepted start.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            n_r <= i_n;
            y_r <= i_y;
            d_r <= i_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r      <= EXP_IDLE;
            bit_r        <= '0;
            m_r          <= '0;
            t_r          <= '0;
            prep_start_r <= 1'b0;
            o_result     <= '0;
            o_busy       <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            prep_start_r <= 1'b0; // strobes default low.
            o_done       <= 1'b0;
            case (state_r)
                EXP_IDLE: begin
                    if (accept) begin
                        prep_start_r <= 1'b1;
                        o_busy       <= 1'b1;
                        m_r          <= W'(1); // plain 1, so each product stays plain.
                        bit_r        <= '0;
                        state_r      <= EXP_PREP;
                    end
                end
                EXP_PREP: begin
                    if (i_prep_done) begin
                        t_r     <= i_prep_t; // y*R mod N starts the power chain.
                        state_r <= EXP_LAUNCH;
                    end
                end
                EXP_LAUNCH: begin
                    state_r <= EXP_WAIT; // the multipliers sample m and t on this edge.
                end
                EXP_WAIT: begin
                    if (i_mont_done) begin
                        if (exp_bit) begin
                            m_r <= i_mul_m; // m*t*R^-1 multiplies in y^(2^i).
                        end
                        t_r <= i_sq_m;      // the square is always taken.
                        if (last_round) begin
                            state_r <= EXP_DONE;
                        end else begin
                            bit_r   <= bit_r + 1'b1;
                            state_r <= EXP_LAUNCH;
                        end
                    end
                end
                EXP_DONE: begin
                    o_result <= m_r; // held until the next run completes.
                    o_done   <= 1'b1;
                    o_busy   <= 1'b0;
                    state_r  <= EXP_IDLE;
                end
                default: state_r <= EXP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rsa_top.sv ====
`default_nettype none

`include "rsa_cfg.svh"

module rsa_top (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_start,
    input  wire logic [`RSA_WIDTH-1:0] i_n,
    input  wire logic [`RSA_WIDTH-1:0] i_y,
    input  wire logic [`RSA_WIDTH-1:0] i_d,
    output logic      [`RSA_WIDTH-1:0] o_result,
    output logic                       o_busy,
    output logic                       o_done
);

    logic prep_start;                   // controller to pre-processor.
    logic prep_done;
    logic mont_start;                   // shared by both multipliers.
    logic mont_done;                    // taken from the squaring unit only.
    logic [`RSA_WIDTH-1:0] n_op;        // registered modulus.
    logic [`RSA_WIDTH-1:0] y_op;
    logic [`RSA_WIDTH-1:0] m_op;        // running result into the multiply unit.
    logic [`RSA_WIDTH-1:0] t_op;        // running power into both units.
    logic [`RSA_WIDTH-1:0] prep_t;
    logic [`RSA_WIDTH-1:0] mul_m;
    logic [`RSA_WIDTH-1:0] sq_m;

    rsa_exp_ctrl exp_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_prep_done  (prep_done),
        .i_mont_done  (mont_done),
        .i_n          (i_n),
        .i_y          (i_y),
        .i_d          (i_d),
        .i_prep_t     (prep_t),
        .i_mul_m      (mul_m),
        .i_sq_m       (sq_m),
        .o_prep_start (prep_start),
        .o_mont_start (mont_start),
        .o_n          (n_op),
        .o_y          (y_op),
        .o_m          (m_op),
        .o_t          (t_op),
        .o_result     (o_result),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    rsa_prep prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start),
        .i_n     (n_op),
        .i_y     (y_op),
        .o_t     (prep_t),
        .o_done  (prep_done)
    );

    // the multiply unit has the same fixed latency as the squaring unit, so its done is not needed.
    rsa_mont mont_mul (
        .i_clk (i_clk), .i_rst (i_rst), .i_start (mont_start), .i_n (n_op),
        .i_a   (m_op),  .i_b   (t_op),  .o_m     (mul_m),      .o_done ()
    );

    rsa_mont mont_sq (
        .i_clk (i_clk), .i_rst (i_rst), .i_start (mont_start), .i_n (n_op),
        .i_a   (t_op),  .i_b   (t_op),  .o_m     (sq_m),       .o_done (mont_done)
    );

endmodule

`default_nettype wire

// ==== tb/tb_rsa_model.svh ====
`ifndef TB_RSA_MODEL_SVH
`define TB_RSA_MODEL_SVH

// modular product from the full 512-bit integer product and a plain remainder.
function automatic logic [OPW-1:0] model_modmul(input logic [OPW-1:0] a,
                                                input logic [OPW-1:0] b,
                                                input logic [OPW-1:0] n);
    logic [2*OPW-1:0] prod;
    logic [2*OPW-1:0] rem;
    prod = {{OPW{1'b0}}, a} * {{OPW{1'b0}}, b};
    rem  = prod % {{OPW{1'b0}}, n};   // the remainder always fits the operand width.
    return rem[OPW-1:0];
endfunction

// right-to-left square-and-multiply on ordinary integers, no Montgomery form.
function automatic logic [OPW-1:0] model_modexp(input logic [OPW-1:0] n,
                                                input logic [OPW-1:0] y,
                                                input logic [OPW-1:0] d);
    logic [OPW-1:0] acc;
    logic [OPW-1:0] pw;
    int i;
    acc = model_modmul(OPW'(1), OPW'(1), n);    // 1 mod n.
    pw  = model_modmul(y, OPW'(1), n);          // y mod n.
    for (i = 0; i < OPW; i++) begin
        if (d[i]) begin
            acc = model_modmul(acc, pw, n);
        end
        pw = model_modmul(pw, pw, n);           // y^(2^(i+1)).
    end
    return acc;
endfunction

// full-width random word built from 32-bit pieces of the seeded generator.
function automatic logic [OPW-1:0] random_operand();
    logic [OPW-1:0] w;
    int k;
    w = '0;
    for (k = 0; k < OPW / 32; k++) begin
        w = {w[OPW-33:0], $unsigned($random(seed))};
    end
    return w;
endfunction

// odd modulus with the top bit set, as the engine requires.
function automatic logic [OPW-1:0] random_modulus();
    logic [OPW-1:0] w;
    w = random_operand();
    w[OPW-1] = 1'b1;
    w[0] = 1'b1;
    return w;
endfunction

task automatic check_result(input logic [OPW-1:0] got, input logic [OPW-1:0] exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[ERROR] %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

// ==== tb/tb_rsa_top.sv ====
`default_nettype none

`include "rsa_cfg.svh"

module tb_rsa_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int OPW = `RSA_WIDTH;
    localparam int DONE_TIMEOUT = 100000;   // one run needs roughly 66300 cycles.
    localparam int MID_RUN_CYCLES = 20000;  // well inside the loop phase of a run.

    logic i_clk;
    logic i_rst;
    logic i_start;
    logic [OPW-1:0] i_n;
    logic [OPW-1:0] i_y;
    logic [OPW-1:0] i_d;
    logic [OPW-1:0] o_result;
    logic o_busy;
    logic o_done;
    int error_count;
    int check_count;
    integer seed;

    `include "tb_rsa_model.svh"

    rsa_top rsa_top_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_y      (i_y),
        .i_d      (i_d),
        .o_result (o_result),
        .o_busy   (o_busy),
        .o_done   (o_done)
    );

    always #2 i_clk = ~i_clk; // 4 ns period.

    // inputs change on the falling edge, half a cycle ahead of the DUT's sampling edge.
    task automatic pulse_start(input logic [OPW-1:0] n, input logic [OPW-1:0] y,
                               input logic [OPW-1:0] d);
        i_n = n;
        i_y = y;
        i_d = d;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;   // operands stay on the inputs.
    endtask

    // polls on falling edges, where the registered outputs are settled.
    task automatic wait_for_done(output logic seen, output logic busy_held);
        int cycles;
        seen = 1'b0;
        busy_held = 1'b1;
        cycles = 0;
        while (!seen && (cycles < DONE_TIMEOUT)) begin
            if (o_done === 1'b1) begin
                seen = 1'b1;
            end else begin
                if (o_busy !== 1'b1) busy_held = 1'b0; // busy must cover the whole run.
                @(negedge i_clk);
                cycles++;
            end
        end
        if (!seen) begin
            error_count++;
            $display("timeout: o_done did not arrive within %0d clock cycles", DONE_TIMEOUT);
        end
    endtask

    // one complete run; it returns in the cycle after o_done, ready for the next start.
    task automatic run_check(input logic [OPW-1:0] n, input logic [OPW-1:0] y,
                             input logic [OPW-1:0] d, input logic [OPW-1:0] expected,
                             input string what);
        logic seen;
        logic busy_held;
        logic [OPW-1:0] held;
        pulse_start(n, y, d);
        wait_for_done(seen, busy_held);
        if (seen) begin
            check_result(o_result, expected, what);
            check_bit(busy_held, 1'b1, {what, ": o_busy high during the run"});
            check_bit(o_busy, 1'b0, {what, ": o_busy low in the done cycle"});
            held = o_result;
            @(negedge i_clk);
            check_bit(o_done, 1'b0, {what, ": o_done lasts one cycle"});
            check_result(o_result, held, {what, ": o_result held after done"});
        end
    endtask

    task automatic test_reset_state();
        check_bit(o_busy, 1'b0, "o_busy after reset");
        check_bit(o_done, 1'b0, "o_done after reset");
        check_result(o_result, '0, "o_result after reset");
    endtask

    task automatic test_small_vectors();
        // the model is first held against two results known by hand.
        check_result(model_modexp(OPW'(7), OPW'(3), OPW'(5)), OPW'(5), "model 3^5 mod 7");
        check_result(model_modexp(OPW'(497), OPW'(4), OPW'(13)), OPW'(445), "model 4^13 mod 497");
        run_check(OPW'(7), OPW'(3), OPW'(5), model_modexp(OPW'(7), OPW'(3), OPW'(5)),
                  "3^5 mod 7");
        run_check(OPW'(497), OPW'(4), OPW'(13), model_modexp(OPW'(497), OPW'(4), OPW'(13)),
                  "4^13 mod 497");
    endtask

    task automatic test_edge_exponents();
        logic [OPW-1:0] n;
        logic [OPW-1:0] y;
        logic [OPW-1:0] d;
        n = random_modulus();
        y = random_operand() % n;       // base must lie below the modulus.
        d = random_operand() | OPW'(1); // nonzero exponent.
        run_check(n, y, '0, OPW'(1), "exponent 0");
        run_check(n, y, OPW'(1), y, "exponent 1");
        run_check(n, '0, d, '0, "zero base");
    endtask

    task automatic test_random_vectors();
        logic [OPW-1:0] n;
        logic [OPW-1:0] y;
        logic [OPW-1:0] d;
        int k;
        for (k = 0; k < 8; k++) begin
            n = random_modulus();
            y = random_operand() % n;
            d = random_operand();
            run_check(n, y, d, model_modexp(n, y, d), $sformatf("random vector %0d", k));
        end
    endtask

    task automatic test_start_while_busy();
        logic [OPW-1:0] n1;
        logic [OPW-1:0] y1;
        logic [OPW-1:0] d1;
        logic [OPW-1:0] n2;
        logic seen;
        logic busy_held;
        n1 = random_modulus();
        y1 = random_operand() % n1;
        d1 = random_operand();
        n2 = random_modulus();
        pulse_start(n1, y1, d1);
        repeat (MID_RUN_CYCLES) @(negedge i_clk);
        check_bit(o_busy, 1'b1, "o_busy mid-run");
        pulse_start(n2, random_operand() % n2, random_operand()); // must be ignored.
        wait_for_done(seen, busy_held);
        if (seen) begin
            check_result(o_result, model_modexp(n1, y1, d1), "start while busy");
            check_bit(busy_held, 1'b1, "o_busy held through the ignored start");
            @(negedge i_clk);
            check_bit(o_done, 1'b0, "no extra o_done after the ignored start");
        end
    endtask

    task automatic test_back_to_back();
        logic [OPW-1:0] n;
        logic [OPW-1:0] y;
        logic [OPW-1:0] d;
        int k;
        for (k = 0; k < 2; k++) begin
            n = random_modulus();
            y = random_operand() % n;
            d = random_operand();
            // run_check returns in the cycle after o_done, so the next start follows at once.
            run_check(n, y, d, model_modexp(n, y, d), $sformatf("back-to-back run %0d", k));
        end
        for (k = 0; k < 4; k++) begin
            check_bit(o_done, 1'b0, "o_done quiet after the last run");
            check_result(o_result, model_modexp(n, y, d), "o_result stable when idle");
            @(negedge i_clk);
        end
    endtask

    initial begin
        seed = 32'hbe6e;
        error_count = 0;
        check_count = 0;
        i_clk = 1'b0;
        i_rst = 1'b0;        // reset is active from time zero.
        i_start = 1'b0;
        i_n = '0;
        i_y = '0;
        i_d = '0;
        repeat (5) @(negedge i_clk);
        i_rst = 1'b1;
        @(negedge i_clk);
        test_reset_state();
        test_small_vectors();
        test_edge_exponents();
        test_random_vectors();
        test_start_while_busy();
        test_back_to_back();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
+incdir+tb
design/rsa_pkg.sv
design/rsa_mont.sv
design/rsa_prep.sv
design/rsa_exp_ctrl.sv
design/rsa_top.sv
tb/tb_rsa_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --timing --timescale 1ns/100ps
TOP        ?= tb_rsa_top
RTL_TOP    ?= rsa_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) design/*.sv design/*.svh tb/*.sv tb/*.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
